// File: src/engine_pkg.sv
// ALU engine shared definitions
`default_nettype none

package engine_pkg;

  // --------------------------------------------------------------------------
  // Packet geometry
  // --------------------------------------------------------------------------

  // Register map below assumes four fields
  localparam int ENGINE_PACKET_DATA_NUM_FIELDS = 4;
  localparam int ENGINE_FIELD_WIDTH            = 32;

  // Per-field sequence state
  typedef enum logic [1:0] {
    SEQUENCE_INVALID = 2'b00,
    SEQUENCE_RUNNING = 2'b01,
    SEQUENCE_DONE    = 2'b10,
    SEQUENCE_END     = 2'b11
  } sequence_state_t;

  // ALU opcodes, 6 and 7 undefined
  typedef enum logic [2:0] {
    ALU_NOP = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2,
    ALU_MUL = 3'd3,
    ALU_ACC = 3'd4,
    ALU_DIV = 3'd5
  } alu_operation_t;

  // Fields in the upper bits, states in the lower bits (136 bits)
  typedef struct packed {
    logic [ENGINE_PACKET_DATA_NUM_FIELDS-1:0][ENGINE_FIELD_WIDTH-1:0] field;
    sequence_state_t [ENGINE_PACKET_DATA_NUM_FIELDS-1:0]              field_state;
  } EnginePacketData;

  // --------------------------------------------------------------------------
  // Configuration
  // --------------------------------------------------------------------------

  typedef struct packed {
    // One row per lane, one bit per source field
    logic [ENGINE_PACKET_DATA_NUM_FIELDS-1:0][ENGINE_PACKET_DATA_NUM_FIELDS-1:0] ops_mask;
    logic [ENGINE_PACKET_DATA_NUM_FIELDS-1:0]                                   const_mask;
    logic [ENGINE_FIELD_WIDTH-1:0]                                              const_value;
    logic [ENGINE_PACKET_DATA_NUM_FIELDS-1:0]                                   alu_mask;
    alu_operation_t                                                             alu_operation;
  } ALUOpsConfigurationParameters;

  // APB register offsets
  localparam logic [3:0] ENGINE_REG_CTRL  = 4'h0;
  localparam logic [3:0] ENGINE_REG_MASKS = 4'h4;
  localparam logic [3:0] ENGINE_REG_CONST = 4'h8;
  localparam logic [3:0] ENGINE_REG_ID    = 4'hC;

  // Read-only block identifier
  localparam logic [31:0] ENGINE_ID_VALUE = 32'h414C_5530;

endpackage : engine_pkg

`default_nettype wire

// File: src/engine_packet_if.sv
// Valid/ready packet link
`default_nettype none

interface engine_packet_if #(
  parameter type payload_t = logic [7:0]
) ();

  // Beat moves when valid and ready are both high
  logic     valid;
  logic     ready;
  payload_t payload;

  // Producer side
  modport source (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side, ready reflects free space
  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface : engine_packet_if

`default_nettype wire

// File: src/engine_apb_config.sv
// ALU engine APB register block
`default_nettype none

module engine_apb_config (
  input  logic                                     ap_clk,
  input  logic                                     areset,
  input  logic [3:0]                               paddr,
  input  logic                                     psel,
  input  logic                                     penable,
  input  logic                                     pwrite,
  input  logic [31:0]                              pwdata,
  output logic [31:0]                              prdata,
  output logic                                     pready,
  output logic                                     pslverr,
  output engine_pkg::ALUOpsConfigurationParameters config_params,
  output logic                                     clear
);

  import engine_pkg::*;

  logic access;
  logic addr_ok;
  logic wr_en;

  // --------------------------------------------------------------------------
  // Access decode
  // --------------------------------------------------------------------------

  // Never stretch a transfer
  assign pready = 1'b1;
  assign access = psel & penable;

  // ID is read-only, unlisted offsets are errors
  always_comb begin
    case (paddr)
      ENGINE_REG_CTRL,
      ENGINE_REG_MASKS,
      ENGINE_REG_CONST: addr_ok = 1'b1;
      ENGINE_REG_ID:    addr_ok = !pwrite;
      default:          addr_ok = 1'b0;
    endcase
  end

  assign pslverr = access & !addr_ok;
  assign wr_en   = access & pwrite & addr_ok;

  // --------------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      config_params <= '0;
      clear         <= 1'b0;
    end else begin
      // Single-cycle pulse from CTRL bit 8
      clear <= wr_en && (paddr == ENGINE_REG_CTRL) && pwdata[8];
      if (wr_en) begin
        case (paddr)
          ENGINE_REG_CTRL: begin
            config_params.alu_operation <= alu_operation_t'(pwdata[2:0]);
            config_params.alu_mask      <= pwdata[7:4];
          end
          ENGINE_REG_MASKS: begin
            // Lane i lives in nibble i
            config_params.ops_mask   <= pwdata[15:0];
            config_params.const_mask <= pwdata[19:16];
          end
          ENGINE_REG_CONST: begin
            config_params.const_value <= pwdata;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Read data valid during the access phase
  always_comb begin
    prdata = '0;
    case (paddr)
      ENGINE_REG_CTRL: begin
        // Clear bit always reads as zero
        prdata[2:0] = config_params.alu_operation;
        prdata[7:4] = config_params.alu_mask;
      end
      ENGINE_REG_MASKS: begin
        prdata[15:0]  = config_params.ops_mask;
        prdata[19:16] = config_params.const_mask;
      end
      ENGINE_REG_CONST: prdata = config_params.const_value;
      ENGINE_REG_ID:    prdata = ENGINE_ID_VALUE;
      default:          prdata = '0;
    endcase
  end

endmodule : engine_apb_config

`default_nettype wire

// File: src/engine_alu_ops_kernel.sv
// ALU engine lane routing and arithmetic pipeline
`default_nettype none

module engine_alu_ops_kernel (
  input  logic                                     ap_clk,
  input  logic                                     areset,
  input  logic                                     clear,
  input  engine_pkg::ALUOpsConfigurationParameters config_params_in,
  input  logic                                     data_valid,
  input  engine_pkg::EnginePacketData              data_in,
  output logic                                     valid_out,
  output engine_pkg::EnginePacketData              result_out
);

  import engine_pkg::*;

  localparam int N     = ENGINE_PACKET_DATA_NUM_FIELDS;
  localparam int IDX_W = $clog2(N);

  // Stage 1 registers
  EnginePacketData ops_s1;
  EnginePacketData org_s1;
  logic [N-1:0]    alu_mask_s1;
  alu_operation_t  alu_op_s1;
  logic            valid_s1;

  // Stage 2 registers
  logic [ENGINE_FIELD_WIDTH-1:0] result_s2;
  EnginePacketData               org_s2;
  logic                          valid_s2;

  // Selected lanes
  logic                          pair_hit;
  logic [IDX_W-1:0]              pair_idx;
  logic                          acc_hit;
  logic [IDX_W-1:0]              acc_idx;
  logic [ENGINE_FIELD_WIDTH-1:0] lane_a;
  logic [ENGINE_FIELD_WIDTH-1:0] lane_b;

  // Valid tags follow the data through all three stages
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      valid_s1  <= 1'b0;
      valid_s2  <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      valid_s1  <= data_valid;
      valid_s2  <= valid_s1;
      valid_out <= valid_s2;
    end
  end

  // --------------------------------------------------------------------------
  // Stage 1: operand and original lanes
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    alu_mask_s1 <= config_params_in.alu_mask;
    alu_op_s1   <= config_params_in.alu_operation;
    for (int i = 0; i < N; i++) begin
      // Constant wins over routing
      if (config_params_in.const_mask[i]) begin
        ops_s1.field[i]       <= config_params_in.const_value;
        ops_s1.field_state[i] <= SEQUENCE_RUNNING;
      end else begin
        ops_s1.field[i]       <= '0;
        ops_s1.field_state[i] <= SEQUENCE_INVALID;
        // Later assignment wins, so the highest set bit picks the field
        for (int j = 0; j < N; j++) begin
          if (config_params_in.ops_mask[i][j]) begin
            ops_s1.field[i]       <= data_in.field[j];
            ops_s1.field_state[i] <= data_in.field_state[j];
          end
        end
      end
      // Empty row keeps the field in place
      org_s1.field[i]       <= data_in.field[i];
      org_s1.field_state[i] <= data_in.field_state[i];
      for (int j = 0; j < N; j++) begin
        if (config_params_in.ops_mask[i][j]) begin
          org_s1.field[i]       <= data_in.field[j];
          org_s1.field_state[i] <= data_in.field_state[j];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stage 2: ALU
  // --------------------------------------------------------------------------

  // Highest mask bit selects the lane
  always_comb begin
    pair_hit = 1'b0;
    pair_idx = '0;
    acc_hit  = 1'b0;
    acc_idx  = '0;
    for (int i = 0; i < N; i++) begin
      if (alu_mask_s1[i]) begin
        acc_hit = 1'b1;
        acc_idx = IDX_W'(i);
        // Pair ops need a right-hand neighbour
        if (i < N - 1) begin
          pair_hit = 1'b1;
          pair_idx = IDX_W'(i);
        end
      end
    end
    lane_a = ops_s1.field[pair_idx];
    lane_b = ops_s1.field[pair_idx + 1'b1];
  end

  // Result doubles as the accumulator, so it only moves on valid beats
  always_ff @(posedge ap_clk) begin
    if (areset || clear) begin
      result_s2 <= '0;
    end else if (valid_s1) begin
      case (alu_op_s1)
        ALU_ADD: if (pair_hit) result_s2 <= lane_a + lane_b;
        ALU_SUB: begin
          // Absolute difference
          if (pair_hit) begin
            result_s2 <= (lane_a > lane_b) ? lane_a - lane_b : lane_b - lane_a;
          end
        end
        // Low half of the product
        ALU_MUL: if (pair_hit) result_s2 <= lane_a * lane_b;
        ALU_ACC: if (acc_hit) result_s2 <= result_s2 + ops_s1.field[acc_idx];
        ALU_NOP,
        ALU_DIV: result_s2 <= ops_s1.field[0];
        default: result_s2 <= ops_s1.field[0];
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    org_s2 <= org_s1;
  end

  // --------------------------------------------------------------------------
  // Stage 3: output packet
  // --------------------------------------------------------------------------

  // Field 0 keeps the original state of field 0
  always_ff @(posedge ap_clk) begin
    result_out          <= org_s2;
    result_out.field[0] <= result_s2;
  end

endmodule : engine_alu_ops_kernel

`default_nettype wire

// File: src/engine_packet_fifo.sv
// Synchronous packet FIFO
`default_nettype none

module engine_packet_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  FIFO_DEPTH = 4
) (
  input  logic                               ap_clk,
  input  logic                               areset,
  engine_packet_if.sink                      wr,
  output logic                               rd_valid,
  input  logic                               rd_ready,
  output payload_t                           rd_data,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]    free_count
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Full flag drives the write-side ready
  assign wr.ready   = (count != CNT_W'(FIFO_DEPTH));
  assign wr_en      = wr.valid & wr.ready;
  assign rd_valid   = (count != '0);
  assign rd_en      = rd_valid & rd_ready;
  assign free_count = CNT_W'(FIFO_DEPTH) - count;

  // Head entry comes straight out of the storage flops
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr.payload;
    end
  end

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap explicitly, depth need not be a power of two
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : engine_packet_fifo

`default_nettype wire

// File: src/engine_alu_ops_stage.sv
// ALU engine stage with credit flow control
`default_nettype none

module engine_alu_ops_stage #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                     ap_clk,
  input  logic                                     areset,
  input  logic                                     clear,
  input  engine_pkg::ALUOpsConfigurationParameters config_params,
  input  logic                                     in_valid,
  output logic                                     in_ready,
  input  engine_pkg::EnginePacketData              in_data,
  output logic                                     out_valid,
  input  logic                                     out_ready,
  output engine_pkg::EnginePacketData              out_data
);

  import engine_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [CNT_W-1:0] free_count;
  logic [CNT_W-1:0] in_flight;
  logic             ready_en;
  logic             accept;

  // Kernel output toward the FIFO write port
  engine_packet_if #(.payload_t(EnginePacketData)) kernel_if ();

  // --------------------------------------------------------------------------
  // Credit check
  // --------------------------------------------------------------------------

  // Holds ready low through reset
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
    end
  end

  // Every packet inside the kernel already owns a FIFO slot
  assign in_ready = ready_en && (free_count > in_flight);
  assign accept   = in_valid && in_ready;

  // Up on accept, down when the kernel hands a packet to the FIFO
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + CNT_W'(accept) - CNT_W'(kernel_if.valid);
    end
  end

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------

  engine_alu_ops_kernel u_kernel (
    .ap_clk           (ap_clk),
    .areset           (areset),
    .clear            (clear),
    .config_params_in (config_params),
    .data_valid       (accept),
    .data_in          (in_data),
    .valid_out        (kernel_if.valid),
    .result_out       (kernel_if.payload)
  );

  // Output skid buffer
  engine_packet_fifo #(
    .payload_t  (EnginePacketData),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .wr         (kernel_if.sink),
    .rd_valid   (out_valid),
    .rd_ready   (out_ready),
    .rd_data    (out_data),
    .free_count (free_count)
  );

endmodule : engine_alu_ops_stage

`default_nettype wire

// File: src/engine_alu_ops_top.sv
// ALU engine top level
`default_nettype none

module engine_alu_ops_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic         ap_clk,
  input  logic         areset,
  // APB slave
  input  logic [3:0]   paddr,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  logic [31:0]  pwdata,
  output logic [31:0]  prdata,
  output logic         pready,
  output logic         pslverr,
  // Packet input
  input  logic         in_valid,
  output logic         in_ready,
  input  logic [127:0] in_fields,
  input  logic [7:0]   in_states,
  // Packet output
  output logic         out_valid,
  input  logic         out_ready,
  output logic [127:0] out_fields,
  output logic [7:0]   out_states
);

  import engine_pkg::*;

  ALUOpsConfigurationParameters config_params;
  logic                         clear;
  EnginePacketData              in_data;
  EnginePacketData              out_data;

  // Flat ports follow the struct layout, fields above states
  assign in_data                  = {in_fields, in_states};
  assign {out_fields, out_states} = out_data;

  engine_apb_config u_config (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .config_params (config_params),
    .clear         (clear)
  );

  engine_alu_ops_stage #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_stage (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .clear         (clear),
    .config_params (config_params),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_data       (in_data),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_data      (out_data)
  );

endmodule : engine_alu_ops_top

`default_nettype wire

// File: verif/engine_alu_ops_model.svh
// ALU engine reference model
`ifndef ENGINE_ALU_OPS_MODEL_SVH
`define ENGINE_ALU_OPS_MODEL_SVH

// Software copy of the configuration registers
logic [2:0]   cfg_op;
logic [3:0]   cfg_alu_mask;
logic [15:0]  cfg_ops_mask;
logic [3:0]   cfg_const_mask;
logic [31:0]  cfg_const_value;

// Result register, also the running sum for ACC
logic [31:0]  model_result;

// Expected output beats, {fields, states}
logic [135:0] expected_q[$];

// Highest set bit among the lowest n bits, -1 if none
function automatic int highest_bit(input logic [3:0] bits, input int n);
  int pos;
  pos = -1;
  for (int k = 0; k < n; k++) begin
    if (bits[k]) begin
      pos = k;
    end
  end
  return pos;
endfunction

// Predict one accepted packet and queue the expected beat
task automatic model_accept(input logic [127:0] f_in, input logic [7:0] s_in);
  logic [31:0]  lane [4];
  logic [127:0] f_out;
  logic [7:0]   s_out;
  int           src;
  int           pair;
  int           sel;
  for (int i = 0; i < 4; i++) begin
    src = highest_bit(cfg_ops_mask[4*i +: 4], 4);
    // Constant beats routing, empty row gives zero
    if (cfg_const_mask[i]) begin
      lane[i] = cfg_const_value;
    end else if (src >= 0) begin
      lane[i] = f_in[32*src +: 32];
    end else begin
      lane[i] = '0;
    end
    // Originals keep their own field on an empty row
    if (src < 0) begin
      src = i;
    end
    f_out[32*i +: 32] = f_in[32*src +: 32];
    s_out[2*i +: 2]   = s_in[2*src +: 2];
  end
  // Pair ops need a neighbour, so only lanes 0 to 2 qualify
  pair = highest_bit(cfg_alu_mask, 3);
  sel  = highest_bit(cfg_alu_mask, 4);
  case (cfg_op)
    ALU_ADD: if (pair >= 0) model_result = lane[pair] + lane[pair+1];
    ALU_SUB: begin
      if (pair >= 0) begin
        model_result = (lane[pair] > lane[pair+1]) ? lane[pair] - lane[pair+1]
                                                   : lane[pair+1] - lane[pair];
      end
    end
    ALU_MUL: if (pair >= 0) model_result = lane[pair] * lane[pair+1];
    ALU_ACC: if (sel >= 0) model_result = model_result + lane[sel];
    default: model_result = lane[0];
  endcase
  // Result takes field 0, state stays with the original field 0
  f_out[31:0] = model_result;
  expected_q.push_back({f_out, s_out});
endtask

`endif

// File: verif/engine_alu_ops_tb.sv
// ALU engine testbench
`default_nettype none

module engine_alu_ops_tb;

  import engine_pkg::*;

  localparam int TIMEOUT_CYCLES = 1000;

  logic         ap_clk;
  logic         areset;
  logic [3:0]   paddr;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [31:0]  pwdata;
  logic [31:0]  prdata;
  logic         pready;
  logic         pslverr;
  logic         in_valid;
  logic         in_ready;
  logic [127:0] in_fields;
  logic [7:0]   in_states;
  logic         out_valid;
  logic         out_ready;
  logic [127:0] out_fields;
  logic [7:0]   out_states;

  // Run bookkeeping
  string        test_name;
  logic         throttle;
  logic         saw_stall;
  logic         prev_hold;
  logic [135:0] prev_beat;
  longint       cycle_count;
  longint       accept_cycle;
  longint       beat_cycle;

  `include "engine_alu_ops_model.svh"

  engine_alu_ops_top #(
    .FIFO_DEPTH (4)
  ) DUT (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_fields  (in_fields),
    .in_states  (in_states),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_fields (out_fields),
    .out_states (out_states)
  );

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  // --------------------------------------------------------------------------
  // Output checks
  // --------------------------------------------------------------------------

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (!areset) begin
      if (in_valid && !in_ready) begin
        saw_stall <= 1'b1;
      end
      // A stalled beat must stay put
      if (prev_hold) begin
        assert (out_valid && ({out_fields, out_states} == prev_beat))
          else abort_run($sformatf("ERR %s: held beat expected %h actual %h",
                                   test_name, prev_beat, {out_fields, out_states}));
      end
      if (out_valid && out_ready) begin
        assert (expected_q.size() > 0)
          else abort_run("An output beat arrived when no packet was expected");
        assert ({out_fields, out_states} == expected_q[0])
          else abort_run($sformatf("ERR %s: beat expected %h actual %h",
                                   test_name, expected_q[0], {out_fields, out_states}));
        void'(expected_q.pop_front());
        beat_cycle <= cycle_count;
      end
      prev_hold <= out_valid && !out_ready;
      prev_beat <= {out_fields, out_states};
    end
  end

  // Sink side, random gaps only while throttled
  always @(negedge ap_clk) begin
    if (throttle) begin
      out_ready <= ($urandom_range(2, 0) == 0);
    end else begin
      out_ready <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // APB driver
  // --------------------------------------------------------------------------

  task automatic apb_access(input logic [3:0] addr, input logic write, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge ap_clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge ap_clk);
    penable = 1'b1;
    @(posedge ap_clk);
    // Access phase ends on the first edge with pready
    while (!pready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("APB transfer never completed, pready stayed low");
      end
      @(posedge ap_clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge ap_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    assert (err == exp_err)
      else abort_run($sformatf("ERR %s: pslverr on write to %h expected %0b actual %0b",
                               test_name, addr, exp_err, err));
  endtask

  // Read data is only compared on a legal access
  task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, '0, rdata, err);
    assert (err == exp_err)
      else abort_run($sformatf("ERR %s: pslverr on read of %h expected %0b actual %0b",
                               test_name, addr, exp_err, err));
    assert (exp_err || (rdata == exp_data))
      else abort_run($sformatf("ERR %s: read of %h expected %h actual %h",
                               test_name, addr, exp_data, rdata));
  endtask

  task automatic set_config(input logic [2:0] op, input logic [3:0] alu_mask,
                            input logic [15:0] ops_mask, input logic [3:0] const_mask,
                            input logic [31:0] const_value);
    apb_write(ENGINE_REG_CTRL, {24'd0, alu_mask, 1'b0, op}, 1'b0);
    apb_write(ENGINE_REG_MASKS, {12'd0, const_mask, ops_mask}, 1'b0);
    apb_write(ENGINE_REG_CONST, const_value, 1'b0);
    cfg_op          = op;
    cfg_alu_mask    = alu_mask;
    cfg_ops_mask    = ops_mask;
    cfg_const_mask  = const_mask;
    cfg_const_value = const_value;
  endtask

  // CTRL rewrite with the clear bit set
  task automatic clear_accumulator();
    apb_write(ENGINE_REG_CTRL, {23'd0, 1'b1, cfg_alu_mask, 1'b0, cfg_op}, 1'b0);
    model_result = '0;
  endtask

  // --------------------------------------------------------------------------
  // Stream driver
  // --------------------------------------------------------------------------

  task automatic send_packet(input logic [127:0] f, input logic [7:0] s);
    int waited;
    waited = 0;
    @(negedge ap_clk);
    in_valid  = 1'b1;
    in_fields = f;
    in_states = s;
    @(posedge ap_clk);
    while (!in_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("Input beat was never accepted, in_ready stayed low");
      end
      @(posedge ap_clk);
    end
    accept_cycle = cycle_count;
    model_accept(f, s);
  endtask

  task automatic send_random(input int count);
    for (int n = 0; n < count; n++) begin
      send_packet({$urandom, $urandom, $urandom, $urandom}, 8'($urandom));
    end
  endtask

  // Stop input, then wait until every expected beat has left
  task automatic drain();
    int waited;
    waited = 0;
    @(negedge ap_clk);
    in_valid = 1'b0;
    while (expected_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run($sformatf("%s: %0d packets never came out of the engine",
                            test_name, expected_q.size()));
      end
      @(posedge ap_clk);
    end
    @(negedge ap_clk);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  initial begin
    logic [3:0] masks [5] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110};
    void'($urandom(32'hb35d_395f));
    areset          = 1'b1;
    paddr           = '0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    pwdata          = '0;
    in_valid        = 1'b0;
    in_fields       = '0;
    in_states       = '0;
    out_ready       = 1'b0;
    throttle        = 1'b0;
    saw_stall       = 1'b0;
    prev_hold       = 1'b0;
    prev_beat       = '0;
    cycle_count     = 0;
    accept_cycle    = 0;
    beat_cycle      = 0;
    model_result    = '0;
    cfg_op          = '0;
    cfg_alu_mask    = '0;
    cfg_ops_mask    = '0;
    cfg_const_mask  = '0;
    cfg_const_value = '0;
    test_name       = "reset";
    repeat (4) @(posedge ap_clk);
    @(negedge ap_clk);
    areset = 1'b0;

    // Register access, bit 8 of CTRL is a write-only clear
    test_name = "apb_registers";
    apb_write(ENGINE_REG_CTRL, 32'h0000_01A3, 1'b0);
    apb_read(ENGINE_REG_CTRL, 32'h0000_00A3, 1'b0);
    apb_write(ENGINE_REG_MASKS, 32'h000F_1234, 1'b0);
    apb_read(ENGINE_REG_MASKS, 32'h000F_1234, 1'b0);
    apb_write(ENGINE_REG_CONST, 32'hDEAD_BEEF, 1'b0);
    apb_read(ENGINE_REG_CONST, 32'hDEAD_BEEF, 1'b0);
    apb_read(ENGINE_REG_ID, ENGINE_ID_VALUE, 1'b0);
    apb_write(ENGINE_REG_ID, 32'hFFFF_FFFF, 1'b1);
    apb_write(4'h2, 32'hFFFF_FFFF, 1'b1);
    apb_read(4'h6, '0, 1'b1);
    // Illegal accesses must not have touched anything
    apb_read(ENGINE_REG_CTRL, 32'h0000_00A3, 1'b0);
    apb_read(ENGINE_REG_MASKS, 32'h000F_1234, 1'b0);
    apb_read(ENGINE_REG_CONST, 32'hDEAD_BEEF, 1'b0);
    apb_read(ENGINE_REG_ID, ENGINE_ID_VALUE, 1'b0);

    // Highest row bit wins, empty rows, constant lanes
    test_name = "routing";
    set_config(ALU_NOP, 4'b0000, 16'h610A, 4'b0100, $urandom);
    send_random(6);
    drain();
    set_config(ALU_NOP, 4'b0001, 16'h0F03, 4'b1001, $urandom);
    send_random(6);
    drain();

    // Pair ops, both operand orderings, overflow
    test_name = "arithmetic";
    for (int op = ALU_ADD; op <= ALU_MUL; op++) begin
      foreach (masks[m]) begin
        set_config(3'(op), masks[m], 16'h8421, 4'b0000, '0);
        send_random(2);
        send_packet({32'h8000_0003, 32'd12, 32'hF000_0001, 32'd5}, 8'h1B);
        send_packet({32'd12, 32'h8000_0003, 32'd5, 32'hF000_0001}, 8'hE4);
        drain();
      end
    end
    // DIV and code 7 fall back to lane 0
    set_config(ALU_DIV, 4'b0011, 16'h1248, 4'b0000, '0);
    send_random(4);
    drain();
    set_config(3'd7, 4'b0110, 16'h8421, 4'b0010, 32'h1234_5678);
    send_random(4);
    drain();

    // Running sums with restarts
    test_name = "accumulate";
    set_config(ALU_ACC, 4'b0100, 16'h8421, 4'b0100, 32'd3);
    clear_accumulator();
    send_random(5);
    drain();
    clear_accumulator();
    send_random(4);
    drain();
    set_config(ALU_ACC, 4'b1001, 16'h8421, 4'b0000, '0);
    clear_accumulator();
    send_random(6);
    drain();

    // Sink stalls against a full-rate source
    test_name = "backpressure";
    set_config(ALU_ADD, 4'b0010, 16'h8421, 4'b0000, '0);
    throttle  = 1'b1;
    saw_stall = 1'b0;
    send_random(40);
    drain();
    throttle = 1'b0;
    assert (saw_stall)
      else abort_run("in_ready never fell while the output was back-pressured");

    // Three kernel cycles plus one in the FIFO
    test_name = "latency";
    set_config(ALU_MUL, 4'b0001, 16'h8421, 4'b0000, '0);
    send_random(1);
    drain();
    assert (beat_cycle - accept_cycle == 4)
      else abort_run($sformatf("ERR %s: latency expected %0d actual %0d",
                               test_name, 4, beat_cycle - accept_cycle));

    if (expected_q.size() != 0) begin
      abort_run("Expected packets were still queued at the end of the run");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule : engine_alu_ops_tb

`default_nettype wire

// File: all.f
+incdir+verif
src/engine_pkg.sv
src/engine_packet_if.sv
src/engine_apb_config.sv
src/engine_alu_ops_kernel.sv
src/engine_packet_fifo.sv
src/engine_alu_ops_stage.sv
src/engine_alu_ops_top.sv
verif/engine_alu_ops_tb.sv
